// File: project.f
+incdir+.
lsu_core_pkg.sv
lsu_mem_pkg.sv
lsu_disp_pick.sv
lsu_sched.sv
lsu_regfile.sv
lsu_pipe.sv
lsu_top.sv
tb_lsu_top.sv

// File: Bender.yml
package:
  name: lsu_cluster

sources:
  - include_dirs:
      - .
    files:
      - lsu_core_pkg.sv
      - lsu_mem_pkg.sv
      - lsu_disp_pick.sv
      - lsu_sched.sv
      - lsu_regfile.sv
      - lsu_pipe.sv
      - lsu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lsu_top.sv

// File: tb_lsu_top.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module tb_lsu_top;
  import lsu_core_pkg::*;
  import lsu_mem_pkg::*;

  localparam int N_TESTS     = 6;
  localparam int CYCLE_LIMIT = 2000;  // per test, also the per-wait bound.

  logic                      clk = 1'b0;
  logic                      rst = 1'b1;
  logic [`LSU_DISP_SIZE-1:0] disp_valid = '0;
  disp_t                     disp [`LSU_DISP_SIZE] = '{default: '0};
  logic                      disp_ready;
  phy_wr_t                   phy_wr_in = '0;
  wb_req_t                   wb_req;
  wb_rsp_t                   wb_rsp = '0;
  phy_wr_t                   phy_wr_out;

  logic [`LSU_XLEN-1:0] mem [1 << `LSU_ADDR_W];
  int                   ack_wait;
  phy_wr_t              wb_exp_q [$];  // loads still owed a writeback.
  wb_req_t              bus_q [$];     // completed bus cycles, oldest first.
  int                   errors = 0;
  int                   n_pass = 0;
  int                   n_fail = 0;

  lsu_top lsu_top_inst (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_disp_valid(disp_valid),
    .i_disp      (disp),
    .o_disp_ready(disp_ready),
    .i_phy_wr    (phy_wr_in),
    .o_wb        (wb_req),
    .i_wb        (wb_rsp),
    .o_phy_wr    (phy_wr_out)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (N_TESTS * CYCLE_LIMIT) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", N_TESTS * CYCLE_LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

  // wishbone slave with a random wait of 0 to 3 cycles before each ack.
  initial begin
    void'($urandom(32'h9be63711));
    forever begin
      @(posedge clk);
      if (rst) begin
        wb_rsp   <= '0;
        ack_wait <= $urandom % 4;
        for (int i = 0; i < (1 << `LSU_ADDR_W); i++) begin
          mem[i] = {i[11:0], 8'h5a, ~i[11:0]};
        end
      end else if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
        if (ack_wait == 0) begin
          wb_rsp.ack <= 1'b1;
          if (wb_req.we) begin
            mem[wb_req.adr] = wb_req.dat_w;
          end else begin
            wb_rsp.dat_r <= mem[wb_req.adr];
          end
          ack_wait <= $urandom % 4;
        end else begin
          ack_wait <= ack_wait - 1;
        end
      end else begin
        wb_rsp.ack <= 1'b0;  // the master drops cyc in the cycle after ack.
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && wb_req.cyc && wb_req.stb && wb_rsp.ack) begin
      bus_q.push_back(wb_req);
    end
  end

  // writebacks may come back in any order, so they are matched by rd.
  always @(posedge clk) begin
    int hit;
    hit = -1;
    if (!rst && phy_wr_out.valid) begin
      for (int i = 0; i < wb_exp_q.size(); i++) begin
        if (hit < 0 && wb_exp_q[i].rd == phy_wr_out.rd) begin
          hit = i;
        end
      end
      if (hit < 0) begin
        $display("unexpected load writeback to register %0d", phy_wr_out.rd);
        errors++;
      end else begin
        check("o_phy_wr.data", phy_wr_out.data, wb_exp_q[hit].data);
        wb_exp_q.delete(hit);
      end
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report(input string name, input int errs_before);
    if (errors == errs_before) begin
      n_pass++;
      $display("%s: ok", name);
    end else begin
      n_fail++;
      $display("%s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // word address as the bus should see it.
  function automatic logic [`LSU_ADDR_W-1:0] eff_addr(input logic [31:0] base, input imm_t imm);
    logic [31:0] sum;
    sum = base + {{16{imm[15]}}, imm};
    return sum[`LSU_ADDR_W-1:0];
  endfunction

  function automatic disp_t load_op(input preg_t rd, input preg_t rs1, input logic rdy,
                                    input imm_t imm);
    return '{is_store: 1'b0, rd: rd, rs1: rs1, rs2: '0, rs1_ready: rdy,
             rs2_ready: 1'b0, imm: imm};
  endfunction

  function automatic disp_t store_op(input preg_t rs1, input preg_t rs2, input imm_t imm);
    return '{is_store: 1'b1, rd: '0, rs1: rs1, rs2: rs2, rs1_ready: 1'b1,
             rs2_ready: 1'b1, imm: imm};
  endfunction

  task automatic set_reg(input preg_t rd, input logic [31:0] data);
    phy_wr_in <= '{valid: 1'b1, rd: rd, data: data};
    @(posedge clk);
    phy_wr_in <= '0;
  endtask

  task automatic expect_load(input preg_t rd, input logic [`LSU_ADDR_W-1:0] addr);
    wb_exp_q.push_back('{valid: 1'b1, rd: rd, data: mem[addr]});
  endtask

  // the group is held until the station takes it.
  task automatic dispatch(input logic [1:0] v, input disp_t d0, input disp_t d1);
    int n;
    n = 0;
    disp_valid <= v;
    disp[0]    <= d0;
    disp[1]    <= d1;
    do begin
      @(posedge clk);
      n++;
    end while (!disp_ready && n < CYCLE_LIMIT);
    if (!disp_ready) begin
      $display("dispatch group was never accepted");
      errors++;
    end
    disp_valid <= '0;
  endtask

  task automatic next_bus(output wb_req_t rec);
    int n;
    n   = 0;
    rec = '0;
    while (bus_q.size() == 0 && n < CYCLE_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (bus_q.size() == 0) begin
      $display("no bus cycle completed within %0d cycles", CYCLE_LIMIT);
      errors++;
    end else begin
      rec = bus_q.pop_front();
    end
  endtask

  task automatic wait_loads();
    int n;
    n = 0;
    while (wb_exp_q.size() != 0 && n < CYCLE_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (wb_exp_q.size() != 0) begin
      $display("%0d load writebacks never arrived", wb_exp_q.size());
      errors++;
      wb_exp_q.delete();
    end
  endtask

  task automatic test_reset_idle();
    int e0;
    e0 = errors;
    repeat (5) begin
      @(posedge clk);
      check("o_wb.cyc", wb_req.cyc, 0);
      check("o_wb.stb", wb_req.stb, 0);
      check("o_phy_wr.valid", phy_wr_out.valid, 0);
      check("o_disp_ready", disp_ready, 1);
    end
    report("reset_idle", e0);
  endtask

  task automatic test_store_load();
    int                     e0;
    wb_req_t                rec;
    logic [`LSU_ADDR_W-1:0] a;
    e0 = errors;
    bus_q.delete();
    set_reg(5'd1, 32'h0000_1230);
    set_reg(5'd2, 32'hdead_beef);
    a = eff_addr(32'h0000_1230, 16'sh0044);  // wraps past the top of the word space.
    dispatch(2'b01, store_op(5'd1, 5'd2, 16'sh0044), '0);
    next_bus(rec);
    check("o_wb.we", rec.we, 1);
    check("o_wb.adr", rec.adr, a);
    check("o_wb.dat_w", rec.dat_w, 32'hdead_beef);
    check("o_wb.sel", rec.sel, 4'hf);
    check("mem", mem[a], 32'hdead_beef);
    wb_exp_q.push_back('{valid: 1'b1, rd: 5'd3, data: 32'hdead_beef});
    dispatch(2'b01, load_op(5'd3, 5'd1, 1'b1, 16'sh0044), '0);
    next_bus(rec);
    check("o_wb.we", rec.we, 0);
    check("o_wb.adr", rec.adr, a);
    wait_loads();
    report("store_load", e0);
  endtask

  task automatic test_regfile_update();
    int                     e0;
    wb_req_t                rec;
    logic [`LSU_ADDR_W-1:0] a1;
    logic [`LSU_ADDR_W-1:0] a2;
    e0 = errors;
    bus_q.delete();
    a1 = eff_addr(32'h0000_1230, -16'sd8);
    a2 = eff_addr(mem[a1], 16'sh0010);
    expect_load(5'd4, a1);
    expect_load(5'd5, a2);
    // the second load waits for the first one's writeback.
    dispatch(2'b11, load_op(5'd4, 5'd1, 1'b1, -16'sd8), load_op(5'd5, 5'd4, 1'b0, 16'sh0010));
    next_bus(rec);
    check("o_wb.adr", rec.adr, a1);
    next_bus(rec);
    check("o_wb.adr", rec.adr, a2);
    wait_loads();
    report("regfile_update", e0);
  endtask

  task automatic test_wakeup();
    int                     e0;
    wb_req_t                rec;
    logic [`LSU_ADDR_W-1:0] a;
    e0 = errors;
    bus_q.delete();
    a = eff_addr(32'h0000_0a08, 16'sh0100);
    expect_load(5'd9, a);
    dispatch(2'b01, load_op(5'd9, 5'd10, 1'b0, 16'sh0100), '0);
    repeat (20) begin
      @(posedge clk);
      check("o_wb.cyc", wb_req.cyc, 0);
    end
    set_reg(5'd10, 32'h0000_0a08);
    next_bus(rec);
    check("o_wb.we", rec.we, 0);
    check("o_wb.adr", rec.adr, a);
    wait_loads();
    report("wakeup", e0);
  endtask

  task automatic test_dual_dispatch();
    int e0;
    e0 = errors;
    expect_load(5'd6, eff_addr(32'h0000_1230, 16'sh0010));
    expect_load(5'd7, eff_addr(32'h0000_1230, 16'sh0020));
    expect_load(5'd8, eff_addr(32'hdead_beef, 16'sh0030));
    dispatch(2'b10, '0, load_op(5'd6, 5'd1, 1'b1, 16'sh0010));
    dispatch(2'b11, load_op(5'd7, 5'd1, 1'b1, 16'sh0020), load_op(5'd8, 5'd2, 1'b1, 16'sh0030));
    wait_loads();
    report("dual_dispatch", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = errors;
    for (int k = 0; k < 4; k++) begin
      expect_load(preg_t'(11 + k), eff_addr(32'h0000_0700, imm_t'(4 * k)));
    end
    dispatch(2'b11, load_op(5'd11, 5'd15, 1'b0, 16'sh0000),
             load_op(5'd12, 5'd15, 1'b0, 16'sh0004));
    dispatch(2'b11, load_op(5'd13, 5'd15, 1'b0, 16'sh0008),
             load_op(5'd14, 5'd15, 1'b0, 16'sh000c));
    @(posedge clk);
    check("o_disp_ready", disp_ready, 0);  // all four entries are taken.
    set_reg(5'd15, 32'h0000_0700);
    wait_loads();
    @(posedge clk);
    check("o_disp_ready", disp_ready, 1);
    report("backpressure", e0);
  endtask

  initial begin
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_reset_idle();
    test_store_load();
    test_regfile_update();
    test_wakeup();
    test_dual_dispatch();
    test_backpressure();
    $display("tests passed %0d, tests failed %0d, errors %0d", n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_top (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic [`LSU_DISP_SIZE-1:0] i_disp_valid,
  input  lsu_core_pkg::disp_t       i_disp [`LSU_DISP_SIZE],
  output logic                      o_disp_ready,
  input  lsu_core_pkg::phy_wr_t     i_phy_wr,
  output lsu_mem_pkg::wb_req_t      o_wb,
  input  lsu_mem_pkg::wb_rsp_t      i_wb,
  output lsu_core_pkg::phy_wr_t     o_phy_wr
);
  import lsu_core_pkg::*;

  logic [1:0]                w_pick_valid;
  disp_t                     w_pick_disp [2];
  logic [`LSU_DISP_SIZE-1:0] w_pick_pos [2];
  phy_wr_t                   w_wakeup [2];
  phy_wr_t                   w_ex3_phy_wr;
  logic                      w_issue_valid;
  issue_t                    w_issue;
  logic                      w_issue_stall;
  preg_t                     w_raddr [2];
  logic [`LSU_XLEN-1:0]      w_rdata [2];
  logic                      w_done;
  rv_idx_t                   w_done_index;

  // external bus first, own writeback second.
  assign w_wakeup[0] = i_phy_wr;
  assign w_wakeup[1] = w_ex3_phy_wr;
  assign o_phy_wr    = w_ex3_phy_wr;

  for (genvar p = 0; p < 2; p++) begin : g_pick
    lsu_disp_pick #(.NUM(p)) u_pick (
      .i_valids(i_disp_valid),
      .i_disp  (i_disp),
      .o_valid (w_pick_valid[p]),
      .o_disp  (w_pick_disp[p]),
      .o_pos   (w_pick_pos[p])
    );
  end

  lsu_sched u_sched (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_in_valid   (w_pick_valid),
    .i_in_disp    (w_pick_disp),
    .i_in_pos     (w_pick_pos),
    .i_wakeup     (w_wakeup),
    .i_issue_stall(w_issue_stall),
    .o_issue_valid(w_issue_valid),
    .o_issue      (w_issue),
    .i_done       (w_done),
    .i_done_index (w_done_index),
    .o_free_ok    (o_disp_ready)
  );

  lsu_regfile u_regfile (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_raddr(w_raddr),
    .o_rdata(w_rdata),
    .i_wr   (w_wakeup)
  );

  lsu_pipe u_pipe (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_issue_valid(w_issue_valid),
    .i_issue      (w_issue),
    .o_issue_stall(w_issue_stall),
    .o_raddr      (w_raddr),
    .i_rdata      (w_rdata),
    .o_wb         (o_wb),
    .i_wb         (i_wb),
    .o_ex3_phy_wr (w_ex3_phy_wr),
    .o_done       (w_done),
    .o_done_index (w_done_index)
  );

endmodule

// File: lsu_pipe.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_pipe (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_issue_valid,
  input  lsu_core_pkg::issue_t  i_issue,
  output logic                  o_issue_stall,
  output lsu_core_pkg::preg_t   o_raddr [2],
  input  logic [`LSU_XLEN-1:0]  i_rdata [2],
  output lsu_mem_pkg::wb_req_t  o_wb,
  input  lsu_mem_pkg::wb_rsp_t  i_wb,
  output lsu_core_pkg::phy_wr_t o_ex3_phy_wr,
  output logic                  o_done,
  output lsu_core_pkg::rv_idx_t o_done_index
);
  import lsu_core_pkg::*;
  import lsu_mem_pkg::*;

  logic                 r_ex1_valid;
  issue_t               r_ex1;
  logic [`LSU_XLEN-1:0] w_ex1_addr;
  logic                 w_ex1_move;
  wb_req_t              r_wb;
  preg_t                r_ex2_rd;
  rv_idx_t              r_ex2_index;
  logic                 w_ex2_ack;
  phy_wr_t              r_ex3_wr;

  assign o_raddr[0] = r_ex1.rs1;  // base.
  assign o_raddr[1] = r_ex1.rs2;  // store data.

  assign w_ex1_addr = i_rdata[0] +
                      {{(`LSU_XLEN-`LSU_IMM_W){r_ex1.imm[`LSU_IMM_W-1]}}, r_ex1.imm};

  // the bus drops cyc for one cycle after ack, so ex1 waits until ex2 is idle.
  assign w_ex1_move    = r_ex1_valid && !r_wb.cyc;
  assign o_issue_stall = r_ex1_valid && r_wb.cyc;
  assign w_ex2_ack     = r_wb.cyc && i_wb.ack;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_ex1_valid <= 1'b0;
    end else if (i_issue_valid) begin
      r_ex1_valid <= 1'b1;
      r_ex1       <= i_issue;
    end else if (w_ex1_move) begin
      r_ex1_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_wb.cyc <= 1'b0;
      r_wb.stb <= 1'b0;
    end else if (w_ex1_move) begin
      r_wb <= '{cyc: 1'b1, stb: 1'b1, we: r_ex1.is_store,
                adr: w_ex1_addr[`LSU_ADDR_W-1:0], dat_w: i_rdata[1], sel: '1};
      r_ex2_rd    <= r_ex1.rd;
      r_ex2_index <= r_ex1.rv_index;
    end else if (w_ex2_ack) begin
      r_wb.cyc <= 1'b0;
      r_wb.stb <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_ex3_wr.valid <= 1'b0;
    end else begin
      r_ex3_wr.valid <= w_ex2_ack && !r_wb.we;  // stores end silently.
    end
    r_ex3_wr.rd   <= r_ex2_rd;
    r_ex3_wr.data <= i_wb.dat_r;
  end

  assign o_wb         = r_wb;
  assign o_ex3_phy_wr = r_ex3_wr;
  assign o_done       = w_ex2_ack;
  assign o_done_index = r_ex2_index;

endmodule

// File: lsu_regfile.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_regfile (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  lsu_core_pkg::preg_t   i_raddr [2],
  output logic [`LSU_XLEN-1:0]  o_rdata [2],
  input  lsu_core_pkg::phy_wr_t i_wr [2]
);

  logic [`LSU_XLEN-1:0] r_regs [`LSU_PREG_NUM];

  // port 1 is the pipe, and its later assignment wins a collision.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `LSU_PREG_NUM; i++) begin
        r_regs[i] <= '0;
      end
    end else begin
      for (int w = 0; w < 2; w++) begin
        if (i_wr[w].valid) begin
          r_regs[i_wr[w].rd] <= i_wr[w].data;
        end
      end
    end
  end

  // same-cycle writes bypass the array.
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      o_rdata[p] = r_regs[i_raddr[p]];
      for (int w = 0; w < 2; w++) begin
        if (i_wr[w].valid && i_wr[w].rd == i_raddr[p]) begin
          o_rdata[p] = i_wr[w].data;
        end
      end
    end
  end

endmodule

// File: lsu_sched.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_sched (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic [1:0]                i_in_valid,
  input  lsu_core_pkg::disp_t       i_in_disp [2],
  input  logic [`LSU_DISP_SIZE-1:0] i_in_pos [2],
  input  lsu_core_pkg::phy_wr_t     i_wakeup [2],
  input  logic                      i_issue_stall,
  output logic                      o_issue_valid,
  output lsu_core_pkg::issue_t      o_issue,
  input  logic                      i_done,
  input  lsu_core_pkg::rv_idx_t     i_done_index,
  output logic                      o_free_ok
);
  import lsu_core_pkg::*;

  localparam int ENT   = `LSU_RV_ENTRIES;
  localparam int AGE_W = $clog2(`LSU_RV_ENTRIES) + 1;

  // age is the rank among live entries, zero being the oldest.
  typedef struct packed {
    logic             is_store;
    preg_t            rd;
    preg_t            rs1;
    preg_t            rs2;
    logic             rs1_rdy;
    logic             rs2_rdy;
    logic             issued;
    imm_t             imm;
    logic [AGE_W-1:0] age;
  } entry_t;

  logic [ENT-1:0]   r_valid;
  entry_t           r_ent [ENT];
  rv_idx_t          w_alloc_idx [2];
  logic [AGE_W-1:0] w_age_ofs [2];
  logic [AGE_W-1:0] w_live_cnt;
  logic [ENT-1:0]   w_ready;
  logic             w_any_ready;
  rv_idx_t          w_oldest;

  function automatic logic wake_hit(input preg_t r);
    logic hit;
    hit = 1'b0;
    for (int w = 0; w < 2; w++) begin
      hit |= i_wakeup[w].valid && (i_wakeup[w].rd == r);
    end
    return hit;
  endfunction

  assign o_free_ok  = $countones(~r_valid) >= `LSU_DISP_SIZE;
  assign w_live_cnt = AGE_W'($countones(r_valid)) - AGE_W'(i_done);

  always_comb begin
    int unsigned n;
    n = 0;
    w_alloc_idx[0] = '0;
    w_alloc_idx[1] = '0;
    for (int i = 0; i < ENT; i++) begin
      if (!r_valid[i]) begin
        if (n < 2) begin
          w_alloc_idx[n] = rv_idx_t'(i);  // lowest free slots first.
        end
        n++;
      end
    end
    for (int k = 0; k < 2; k++) begin
      w_age_ofs[k] = '0;
      for (int j = 0; j < 2; j++) begin
        if (i_in_valid[j] && i_in_pos[j] < i_in_pos[k]) begin
          w_age_ofs[k] = w_age_ofs[k] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    logic [AGE_W-1:0] best;
    best        = '1;
    w_any_ready = 1'b0;
    w_oldest    = '0;
    for (int i = 0; i < ENT; i++) begin
      // loads never read rs2, so only stores wait for it.
      w_ready[i] = r_valid[i] && !r_ent[i].issued && r_ent[i].rs1_rdy &&
                   (r_ent[i].rs2_rdy || !r_ent[i].is_store);
      if (w_ready[i] && (!w_any_ready || r_ent[i].age < best)) begin
        w_any_ready = 1'b1;
        best        = r_ent[i].age;
        w_oldest    = rv_idx_t'(i);
      end
    end
  end

  assign o_issue_valid = w_any_ready && !i_issue_stall;
  assign o_issue = '{is_store: r_ent[w_oldest].is_store, rd: r_ent[w_oldest].rd,
                     rs1: r_ent[w_oldest].rs1, rs2: r_ent[w_oldest].rs2,
                     imm: r_ent[w_oldest].imm, rv_index: w_oldest};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_valid <= '0;
    end else begin
      for (int i = 0; i < ENT; i++) begin
        if (r_valid[i]) begin
          if (wake_hit(r_ent[i].rs1)) begin
            r_ent[i].rs1_rdy <= 1'b1;
          end
          if (wake_hit(r_ent[i].rs2)) begin
            r_ent[i].rs2_rdy <= 1'b1;
          end
          if (i_done && r_ent[i].age > r_ent[i_done_index].age) begin
            r_ent[i].age <= r_ent[i].age - 1'b1;  // close the gap left by the freed entry.
          end
        end
      end
      if (o_issue_valid) begin
        r_ent[w_oldest].issued <= 1'b1;
      end
      if (i_done) begin
        r_valid[i_done_index] <= 1'b0;
      end
      for (int k = 0; k < 2; k++) begin
        if (i_in_valid[k] && o_free_ok) begin
          r_valid[w_alloc_idx[k]] <= 1'b1;
          r_ent[w_alloc_idx[k]] <= '{
            is_store: i_in_disp[k].is_store,
            rd:       i_in_disp[k].rd,
            rs1:      i_in_disp[k].rs1,
            rs2:      i_in_disp[k].rs2,
            rs1_rdy:  i_in_disp[k].rs1_ready || wake_hit(i_in_disp[k].rs1),
            rs2_rdy:  i_in_disp[k].rs2_ready || wake_hit(i_in_disp[k].rs2),
            issued:   1'b0,
            imm:      i_in_disp[k].imm,
            age:      w_live_cnt + w_age_ofs[k]
          };
        end
      end
    end
  end

endmodule

// File: lsu_disp_pick.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_disp_pick #(
  parameter int NUM = 0
) (
  input  logic [`LSU_DISP_SIZE-1:0] i_valids,
  input  lsu_core_pkg::disp_t       i_disp [`LSU_DISP_SIZE],
  output logic                      o_valid,
  output lsu_core_pkg::disp_t       o_disp,
  output logic [`LSU_DISP_SIZE-1:0] o_pos
);

  // walk the slots in order and stop at the set bit of rank NUM.
  always_comb begin
    int unsigned cnt;
    cnt     = 0;
    o_valid = 1'b0;
    o_disp  = '0;
    o_pos   = '0;
    for (int i = 0; i < `LSU_DISP_SIZE; i++) begin
      if (i_valids[i]) begin
        if (cnt == NUM && !o_valid) begin
          o_valid  = 1'b1;
          o_disp   = i_disp[i];
          o_pos[i] = 1'b1;  // position keeps slot order for the age stamp.
        end
        cnt++;
      end
    end
  end

endmodule

// File: lsu_mem_pkg.sv
`include "lsu_params.svh"

package lsu_mem_pkg;

  // signals driven by the master side.
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`LSU_ADDR_W-1:0] adr;
    logic [`LSU_XLEN-1:0]   dat_w;
    logic [`LSU_XLEN/8-1:0] sel;
  } wb_req_t;

  // signals driven by the slave side.
  typedef struct packed {
    logic                 ack;
    logic [`LSU_XLEN-1:0] dat_r;  // valid in the ack cycle only.
  } wb_rsp_t;

endpackage

// File: lsu_core_pkg.sv
`include "lsu_params.svh"

package lsu_core_pkg;

  typedef logic [$clog2(`LSU_PREG_NUM)-1:0]   preg_t;
  typedef logic [$clog2(`LSU_RV_ENTRIES)-1:0] rv_idx_t;
  typedef logic signed [`LSU_IMM_W-1:0]       imm_t;

  typedef struct packed {
    logic  is_store;
    preg_t rd;
    preg_t rs1;
    preg_t rs2;
    logic  rs1_ready;  // operand state as seen by the dispatcher.
    logic  rs2_ready;
    imm_t  imm;
  } disp_t;

  typedef struct packed {
    logic    is_store;
    preg_t   rd;
    preg_t   rs1;
    preg_t   rs2;
    imm_t    imm;
    rv_idx_t rv_index;  // entry to release when the bus cycle ends.
  } issue_t;

  // one write bus doubles as register write and wakeup.
  typedef struct packed {
    logic                 valid;
    preg_t                rd;
    logic [`LSU_XLEN-1:0] data;
  } phy_wr_t;

endpackage

// File: lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// operations offered by the dispatcher per cycle.
`define LSU_DISP_SIZE  2

// reservation station depth.
`define LSU_RV_ENTRIES 4

// physical register count and data width.
`define LSU_PREG_NUM   32
`define LSU_XLEN       32

// the bus carries word addresses only.
`define LSU_ADDR_W     12

// signed immediate carried with each operation.
`define LSU_IMM_W      16

`endif
